// File: spam_cpu_pkg.sv
// shared instruction format; device codes and alu ops fix the layout of program.hex
`default_nettype none

package spam_cpu_pkg;

    localparam int alu_op_w   = 5;
    localparam int abus_dev_w = 4;
    localparam int bbus_dev_w = 4;
    localparam int targ_dev_w = 5;
    localparam int addr_w     = 16;

    typedef logic [7:0] byte_t;

    // lane 6 is the most significant byte of the 48-bit word
    typedef struct packed {
        byte_t lane6;
        byte_t lane5;
        byte_t lane4;
        byte_t lane3;
        byte_t lane2;
        byte_t lane1;
    } instr_t;

    // undefined codes behave as pass_b
    typedef enum logic [alu_op_w-1:0] {
        pass_b = 5'd0,
        add    = 5'd1,
        sub    = 5'd2,
        bxor   = 5'd3
    } alu_op_e;

    typedef enum logic [abus_dev_w-1:0] {
        adev_reg_a = 4'd0,
        adev_reg_b = 4'd1,
        adev_reg_c = 4'd2,
        adev_reg_d = 4'd3,
        adev_zero  = 4'd4
    } abus_dev_e;

    typedef enum logic [bbus_dev_w-1:0] {
        bdev_reg_a = 4'd0,
        bdev_reg_b = 4'd1,
        bdev_reg_c = 4'd2,
        bdev_reg_d = 4'd3,
        bdev_immed = 4'd4
    } bbus_dev_e;

    // upper two bits pick a block of eight devices
    typedef enum logic [targ_dev_w-1:0] {
        tdev_reg_a  = 5'd0,
        tdev_reg_b  = 5'd1,
        tdev_reg_c  = 5'd2,
        tdev_reg_d  = 5'd3,
        tdev_out    = 5'd4,
        tdev_jmp    = 5'd8,
        tdev_jmp_c  = 5'd9,
        tdev_jmp_z  = 5'd10,
        tdev_jmp_nz = 5'd11,
        tdev_halt   = 5'd16,
        tdev_nop    = 5'd31
    } targ_dev_e;

    typedef struct packed {
        alu_op_e                     alu_op;
        logic [2**abus_dev_w-1:0]    abus_sel;
        logic [2**bbus_dev_w-1:0]    bbus_sel;
        logic [2**targ_dev_w-1:0]    targ_sel;
        logic                        amode;
        logic [addr_w-1:0]           jump_addr;
        byte_t                       immed8;
    } ctrl_t;

    typedef struct packed {
        logic carry;
        logic zero;
    } flags_t;

    // pass_b, abus zero, bbus immed, target halt, direct mode
    localparam instr_t halt_instr = 48'h04_11_01_00_00_00;

endpackage

`default_nettype wire

// File: instruction_rom.sv
// async-read program rom from program.hex at elaboration; unlisted words read as halt
`timescale 1ns/1ps
`default_nettype none

module instruction_rom #(
    parameter int rom_awidth = 8
) (
    input  wire [rom_awidth-1:0] addr,
    output spam_cpu_pkg::instr_t instr
);

    localparam int depth = 2 ** rom_awidth;

    spam_cpu_pkg::byte_t lane_6 [depth];
    spam_cpu_pkg::byte_t lane_5 [depth];
    spam_cpu_pkg::byte_t lane_4 [depth];
    spam_cpu_pkg::byte_t lane_3 [depth];
    spam_cpu_pkg::byte_t lane_2 [depth];
    spam_cpu_pkg::byte_t lane_1 [depth];

    // whole words as they sit in the hex file
    logic [47:0] image [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            image[i] = spam_cpu_pkg::halt_instr;
        end
        $readmemh("program.hex", image);
        // spread each word over the six byte lanes
        for (int i = 0; i < depth; i++) begin
            lane_6[i] = image[i][47:40];
            lane_5[i] = image[i][39:32];
            lane_4[i] = image[i][31:24];
            lane_3[i] = image[i][23:16];
            lane_2[i] = image[i][15:8];
            lane_1[i] = image[i][7:0];
        end
    end

    assign instr.lane6 = lane_6[addr];
    assign instr.lane5 = lane_5[addr];
    assign instr.lane4 = lane_4[addr];
    assign instr.lane3 = lane_3[addr];
    assign instr.lane2 = lane_2[addr];
    assign instr.lane1 = lane_1[addr];

endmodule

`default_nettype wire

// File: wide_controller.sv
// purely combinational decode; register-mode jumps use C:D as read this cycle
`timescale 1ns/1ps
`default_nettype none

module wide_controller (
    input  wire spam_cpu_pkg::instr_t instr,
    input  wire [spam_cpu_pkg::addr_w-1:0] reg_cd,
    output spam_cpu_pkg::ctrl_t ctrl
);

    // reg_a to reg_d and zero or immed on both buses
    localparam logic [15:0] bus_known  = 16'h001f;
    // reg_a to out, the four jumps, halt and nop
    localparam logic [31:0] targ_known = 32'h8001_0f1f;

    logic [spam_cpu_pkg::alu_op_w-1:0]   alu_op;
    logic [spam_cpu_pkg::abus_dev_w-1:0] abus_dev;
    logic [spam_cpu_pkg::bbus_dev_w-1:0] bbus_dev;
    logic [spam_cpu_pkg::targ_dev_w-1:0] targ_dev;
    logic                                amode;
    logic [3:0]                          targ_block;

    // one 3-to-8 decoder with active high enable
    function automatic logic [7:0] dec8(input logic [2:0] code, input logic en);
        dec8 = en ? (8'b1 << code) : 8'b0;
    endfunction

    // field split follows the lane layout of the word
    assign alu_op   = instr.lane6[7:3];
    assign targ_dev = {instr.lane6[2:0], instr.lane5[7:6]};
    assign abus_dev = instr.lane5[5:2];
    assign bbus_dev = {instr.lane5[1:0], instr.lane4[7:6]};
    assign amode    = instr.lane4[0];

    // first level of the target decode
    assign targ_block = 4'b0001 << targ_dev[4:3];

    always_comb begin
        ctrl.alu_op   = spam_cpu_pkg::alu_op_e'(alu_op);
        ctrl.abus_sel = {dec8(abus_dev[2:0], abus_dev[3]),
                         dec8(abus_dev[2:0], !abus_dev[3])};
        ctrl.bbus_sel = {dec8(bbus_dev[2:0], bbus_dev[3]),
                         dec8(bbus_dev[2:0], !bbus_dev[3])};
        ctrl.targ_sel = {dec8(targ_dev[2:0], targ_block[3]),
                         dec8(targ_dev[2:0], targ_block[2]),
                         dec8(targ_dev[2:0], targ_block[1]),
                         dec8(targ_dev[2:0], targ_block[0])};
        ctrl.amode    = amode;
        // amode set means direct address, clear means register pair
        ctrl.jump_addr = amode ? {instr.lane3, instr.lane2} : reg_cd;
        ctrl.immed8    = instr.lane1;
    end

    // checked once the fetched word has settled
    always_comb begin
        if (!$isunknown(instr)) begin
            a_abus_onehot: assert final ($onehot(ctrl.abus_sel & bus_known))
                else $error("[ERROR] abus select hits no defined device: %h", ctrl.abus_sel);
            a_bbus_onehot: assert final ($onehot(ctrl.bbus_sel & bus_known))
                else $error("[ERROR] bbus select hits no defined device: %h", ctrl.bbus_sel);
            a_targ_onehot: assert final ($onehot(ctrl.targ_sel & targ_known))
                else $error("[ERROR] target select hits no defined device: %h",
                    ctrl.targ_sel);
        end
    end

endmodule

`default_nettype wire

// File: pc_unit.sv
// pc wraps at 2**rom_awidth; jump addresses keep only their low rom_awidth bits
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
    parameter int rom_awidth = 8
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire spam_cpu_pkg::ctrl_t  ctrl,
    input  wire spam_cpu_pkg::flags_t flags,
    input  wire                       busy,
    output logic [rom_awidth-1:0]     pc,
    output logic                      halted
);

    logic take_jump;

    // flags come from the last register write
    assign take_jump = ctrl.targ_sel[spam_cpu_pkg::tdev_jmp]
        || (ctrl.targ_sel[spam_cpu_pkg::tdev_jmp_c] && flags.carry)
        || (ctrl.targ_sel[spam_cpu_pkg::tdev_jmp_z] && flags.zero)
        || (ctrl.targ_sel[spam_cpu_pkg::tdev_jmp_nz] && !flags.zero);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted && !busy) begin
            if (ctrl.targ_sel[spam_cpu_pkg::tdev_halt]) begin
                halted <= 1'b1;
            end else if (take_jump) begin
                pc <= ctrl.jump_addr[rom_awidth-1:0];
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // halt is final
    a_halt_freezes_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> halted && $stable(pc)
    ) else $error("[ERROR] pc moved or halt cleared after halt");

endmodule

`default_nettype wire

// File: register_bank.sv
// registers A to D only; bus codes with no device read as zero
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire spam_cpu_pkg::ctrl_t ctrl,
    input  wire spam_cpu_pkg::byte_t result,
    input  wire                      busy,
    output spam_cpu_pkg::byte_t      abus,
    output spam_cpu_pkg::byte_t      bbus,
    output logic [15:0]              reg_cd
);

    spam_cpu_pkg::byte_t regs [4];

    // A then B then C then D, codes are consecutive on every bus
    always_comb begin
        abus = '0;
        bbus = '0;
        for (int i = 0; i < 4; i++) begin
            if (ctrl.abus_sel[int'(spam_cpu_pkg::adev_reg_a) + i]) begin
                abus = regs[i];
            end
            if (ctrl.bbus_sel[int'(spam_cpu_pkg::bdev_reg_a) + i]) begin
                bbus = regs[i];
            end
        end
        if (ctrl.bbus_sel[spam_cpu_pkg::bdev_immed]) begin
            bbus = ctrl.immed8;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (!busy) begin
            for (int i = 0; i < 4; i++) begin
                if (ctrl.targ_sel[int'(spam_cpu_pkg::tdev_reg_a) + i]) begin
                    regs[i] <= result;
                end
            end
        end
    end

    // pair for register-mode jumps, C is the high byte
    assign reg_cd = {regs[2], regs[3]};

endmodule

`default_nettype wire

// File: alu.sv
// flags change only on register writes; carry after sub is a borrow
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire spam_cpu_pkg::ctrl_t ctrl,
    input  wire spam_cpu_pkg::byte_t abus,
    input  wire spam_cpu_pkg::byte_t bbus,
    input  wire                      busy,
    output spam_cpu_pkg::byte_t      result,
    output spam_cpu_pkg::flags_t     flags
);

    logic [8:0] sum;
    logic [8:0] diff;
    logic       carry_next;
    logic       writes_reg;

    assign sum  = {1'b0, abus} + {1'b0, bbus};
    assign diff = {1'b0, abus} - {1'b0, bbus};

    always_comb begin
        carry_next = 1'b0;
        case (ctrl.alu_op)
            spam_cpu_pkg::add: begin
                result     = sum[7:0];
                carry_next = sum[8];
            end
            spam_cpu_pkg::sub: begin
                result     = diff[7:0];
                carry_next = diff[8];
            end
            spam_cpu_pkg::bxor: result = abus ^ bbus;
            default: result = bbus;
        endcase
    end

    assign writes_reg = ctrl.targ_sel[spam_cpu_pkg::tdev_reg_a]
        || ctrl.targ_sel[spam_cpu_pkg::tdev_reg_b]
        || ctrl.targ_sel[spam_cpu_pkg::tdev_reg_c]
        || ctrl.targ_sel[spam_cpu_pkg::tdev_reg_d];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (writes_reg && !busy) begin
            flags.carry <= carry_next;
            flags.zero  <= (result == 8'h00);
        end
    end

endmodule

`default_nettype wire

// File: out_port.sv
// single byte buffer; a second write while one is pending stalls the core
`timescale 1ns/1ps
`default_nettype none

module out_port (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire spam_cpu_pkg::ctrl_t ctrl,
    input  wire spam_cpu_pkg::byte_t result,
    output logic                     out_valid,
    output spam_cpu_pkg::byte_t      out_data,
    input  wire                      out_ready,
    output logic                     busy
);

    logic write;
    logic load;

    assign write = ctrl.targ_sel[spam_cpu_pkg::tdev_out];
    assign busy  = write && out_valid && !out_ready;
    // loads also when the old byte leaves on this edge
    assign load  = write && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= result;
        end
    end

    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("[ERROR] output byte changed before acceptance");

endmodule

`default_nettype wire

// File: spam_cpu.sv
// one instruction per clock; out_ready back-pressure stalls the whole core
`timescale 1ns/1ps
`default_nettype none

module spam_cpu #(
    parameter int rom_awidth = 8
) (
    input  wire                 clk,
    input  wire                 rst_n,
    output logic                out_valid,
    output spam_cpu_pkg::byte_t out_data,
    input  wire                 out_ready,
    output logic                halted
);

    spam_cpu_pkg::instr_t  instr;
    spam_cpu_pkg::ctrl_t   ctrl;
    spam_cpu_pkg::flags_t  flags;
    spam_cpu_pkg::byte_t   abus;
    spam_cpu_pkg::byte_t   bbus;
    spam_cpu_pkg::byte_t   result;
    logic [rom_awidth-1:0] pc;
    logic [15:0]           reg_cd;
    logic                  busy;

    instruction_rom #(.rom_awidth(rom_awidth)) i_rom (
        .addr  (pc),
        .instr (instr)
    );

    wide_controller i_ctrl (
        .instr  (instr),
        .reg_cd (reg_cd),
        .ctrl   (ctrl)
    );

    pc_unit #(.rom_awidth(rom_awidth)) i_pc (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .flags  (flags),
        .busy   (busy),
        .pc     (pc),
        .halted (halted)
    );

    register_bank i_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .result (result),
        .busy   (busy),
        .abus   (abus),
        .bbus   (bbus),
        .reg_cd (reg_cd)
    );

    alu i_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .abus   (abus),
        .bbus   (bbus),
        .busy   (busy),
        .result (result),
        .flags  (flags)
    );

    out_port i_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .result    (result),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .busy      (busy)
    );

endmodule

`default_nettype wire

// File: tb_spam_cpu.sv
// run from the project root so program.hex is found; checks only the output port and halt
`timescale 1ns/1ps
`default_nettype none

module tb_spam_cpu;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 3;
    // about 90 instructions plus reset, then a long stall budget per output byte
    localparam int run_cycles   = 100;
    localparam int stall_cycles = 50;
    localparam int out_bytes    = 18;
    localparam int watchdog_ns  = (run_cycles + out_bytes * stall_cycles) * clk_period;

    logic                clk;
    logic                rst_n;
    logic                out_ready;
    logic                out_valid;
    logic                halted;
    spam_cpu_pkg::byte_t out_data;
    spam_cpu_pkg::byte_t last_data;
    spam_cpu_pkg::byte_t expected [32];
    int                  n_expected;
    int                  xfer_count;

    spam_cpu i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .halted    (halted)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    // fibonacci until an add would carry, then the xor, then the countdown
    function automatic void build_expected();
        int a;
        int b;
        int next;
        a = 0;
        b = 1;
        n_expected = 0;
        expected[n_expected++] = 8'(a);
        expected[n_expected++] = 8'(b);
        while (a + b < 256) begin
            next = a + b;
            expected[n_expected++] = 8'(next);
            a = b;
            b = next;
        end
        expected[n_expected++] = 8'(a ^ b);
        for (int c = 3; c > 0; c--) begin
            expected[n_expected++] = 8'(c);
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        out_ready = 1'b0;
        void'($urandom(64995));
        forever begin
            @(posedge clk);
            #1;
            // low about 40% of the time
            out_ready = ($urandom % 100) >= 40;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer_count <= 0;
        end else if (out_valid && out_ready) begin
            xfer_count <= xfer_count + 1;
        end
    end

    always @(posedge clk) begin
        last_data <= out_data;
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid && !halted)
        else report_failure($sformatf("[ERROR] %0t out_valid/halted in reset expected 0/0 got %b/%b",
            $time, $sampled(out_valid), $sampled(halted)));

    a_byte_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_data == expected[xfer_count])
        else report_failure($sformatf("[ERROR] %0t out_data expected %0d got %0d",
            $time, expected[$sampled(xfer_count)], $sampled(out_data)));

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> xfer_count < n_expected)
        else report_failure("a byte was transferred after the expected list ended");

    a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid)
        else report_failure($sformatf("[ERROR] %0t out_valid expected 1 got 0", $time));

    a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_data == last_data)
        else report_failure($sformatf("[ERROR] %0t out_data expected %0d got %0d",
            $time, $sampled(last_data), $sampled(out_data)));

    // last byte may still be pending when halt lands
    a_halt_count: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(halted) |-> xfer_count + int'(out_valid) == n_expected)
        else report_failure($sformatf("[ERROR] %0t bytes produced at halt expected %0d got %0d",
            $time, n_expected, $sampled(xfer_count) + int'($sampled(out_valid))));

    a_halt_stays: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else report_failure($sformatf("[ERROR] %0t halted expected 1 got 0", $time));

    a_drain: assert property (@(posedge clk) disable iff (!rst_n)
        halted && out_valid && out_ready |=> !out_valid)
        else report_failure($sformatf("[ERROR] %0t out_valid after drain expected 0 got 1",
            $time));

    a_quiet_after: assert property (@(posedge clk) disable iff (!rst_n)
        halted && !out_valid |=> !out_valid)
        else report_failure($sformatf("[ERROR] %0t out_valid after halt expected 0 got 1",
            $time));

    a_count_done: assert property (@(posedge clk) disable iff (!rst_n)
        halted && !out_valid |-> xfer_count == n_expected)
        else report_failure($sformatf("[ERROR] %0t xfer_count expected %0d got %0d",
            $time, n_expected, $sampled(xfer_count)));

    initial begin
        #(watchdog_ns);
        report_failure("timeout: the core did not halt and drain its output in time");
    end

    initial begin
        rst_n = 1'b0;
        build_expected();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        while (!halted || out_valid) begin
            @(negedge clk);
        end
        // idle cycles for the after-halt checks
        repeat (4) @(posedge clk);
        #1;
        if (xfer_count == n_expected) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_failure($sformatf("[ERROR] %0t xfer_count expected %0d got %0d",
                $time, n_expected, xfer_count));
        end
    end

endmodule

`default_nettype wire

// File: program.hex
// lanes 6..4 hold alu op, target, abus, bbus, amode; lanes 3..2 jump address; lane 1 immediate
001101000000
005101000001
011001000000
088041000000
025101000800
001041000000
005081000000
021101000200
011041000000
190041000000
009101000003
011081000000
108901000001
02D101000B00
041101000000

// File: spam_cpu.f
spam_cpu_pkg.sv
instruction_rom.sv
wide_controller.sv
pc_unit.sv
register_bank.sv
alu.sv
out_port.sv
spam_cpu.sv
tb_spam_cpu.sv

// File: run.sh
#!/bin/sh
# builds and runs the testbench from the project root; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f spam_cpu.f --top-module tb_spam_cpu -o tb_spam_cpu &&
./obj_dir/tb_spam_cpu || { echo "simulation failed"; exit 1; }
